// File: sources.f
verilog/mm_pkg.sv
verilog/axi_pkg.sv
verilog/dma_cfg_if.sv
verilog/dma_cfg_regs.sv
verilog/dma_engine.sv
verilog/tile_buffer.sv
verilog/mm_engine.sv
verilog/mm_accel_top.sv
sim/tb_axi_mem.sv
sim/tb_mm_accel.sv

// File: Bender.yml
package:
  name: mm_accel

sources:
  - files:
      - verilog/mm_pkg.sv
      - verilog/axi_pkg.sv
      - verilog/dma_cfg_if.sv
      - verilog/dma_cfg_regs.sv
      - verilog/dma_engine.sv
      - verilog/tile_buffer.sv
      - verilog/mm_engine.sv
      - verilog/mm_accel_top.sv
  - target: test
    files:
      - sim/tb_axi_mem.sv
      - sim/tb_mm_accel.sv

// File: sim/tb_mm_accel.sv
/*
 * testbench for the matrix-multiply tile: random matrices and addresses,
 * random bus stalls, reference product in the testbench, seven jobs in a row
 */
`timescale 1ns/1ps

module tb_mm_accel import mm_pkg::*, axi_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_JOBS   = 7;
    localparam int JOB_CYCLES = 400;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              reg_we;
    reg_addr_e         reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic [DATA_W-1:0] reg_rdata;
    logic              done;
    logic              arvalid, arready, rvalid, rready, rlast;
    logic              awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [ADDR_W-1:0] araddr, awaddr;
    logic [DATA_W-1:0] rdata, wdata;
    axi_id_e           arid, rid;
    axi_resp_e         bresp;
    logic              stall_ar, stall_r, stall_aw, stall_w, stall_b;
    logic              interleave;
    logic [9:0]        stall_bits;
    logic [31:0]       lfsr_q = 32'h8a0b_abdb;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mm_accel_top #(.BUF_AW(2)) uut (
        .clk, .rst_n, .reg_we_i (reg_we), .reg_addr_i (reg_addr), .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata), .done_o (done),
        .arvalid_o (arvalid), .arready_i (arready), .araddr_o (araddr), .arid_o (arid),
        .rvalid_i (rvalid), .rready_o (rready), .rdata_i (rdata), .rid_i (rid), .rlast_i (rlast),
        .awvalid_o (awvalid), .awready_i (awready), .awaddr_o (awaddr),
        .wvalid_o (wvalid), .wready_i (wready), .wdata_o (wdata), .wlast_o (wlast),
        .bvalid_i (bvalid), .bready_o (bready), .bresp_i (bresp)
    );

    tb_axi_mem #(.WORDS(1024)) mem_model (
        .clk, .rst_n, .stall_ar_i (stall_ar), .stall_r_i (stall_r), .stall_aw_i (stall_aw),
        .stall_w_i (stall_w), .stall_b_i (stall_b), .interleave_i (interleave),
        .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr), .arid_i (arid),
        .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rid_o (rid), .rlast_o (rlast),
        .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
        .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wlast_i (wlast),
        .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    task automatic check_state(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (act !== exp)
            abort_run($sformatf("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    // bus tasks start and end 1 ns after a rising edge
    task automatic reg_write(input reg_addr_e addr, input logic [DATA_W-1:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [DATA_W-1:0] data);
        reg_addr = addr;
        @(negedge clk);
        data = reg_rdata;
        @(posedge clk);
        #1;
    endtask

    // stall bits drawn at the edge, driven 1 ns later; each stalls 1 cycle in 4
    always @(posedge clk) begin
        stall_bits = 10'(rand_bits(10));
        #1;
        stall_ar = &stall_bits[1:0];
        stall_r  = &stall_bits[3:2];
        stall_aw = &stall_bits[5:4];
        stall_w  = &stall_bits[7:6];
        stall_b  = &stall_bits[9:8];
    end

    // violations logged by the memory model
    always @(posedge clk) begin
        if (mem_model.proto_msg != "")
            abort_run(mem_model.proto_msg);
    end

    task automatic run_job(input int job, input logic ilv);
        logic [ADDR_W-1:0] a_addr, b_addr, c_addr;
        logic [DATA_W-1:0] a_m [TILE_N][TILE_N];
        logic [DATA_W-1:0] b_m [TILE_N][TILE_N];
        logic [DATA_W-1:0] c_exp;
        logic [DATA_W-1:0] rd;
        logic [7:0]        e;
        logic [5:0]        slot_a, slot_b, slot_c;
        // three disjoint 64-byte slots in 4 KB
        slot_a = 6'(rand_bits(6));
        slot_b = 6'(rand_bits(6));
        while (slot_b == slot_a)
            slot_b = 6'(rand_bits(6));
        slot_c = 6'(rand_bits(6));
        while (slot_c == slot_a || slot_c == slot_b)
            slot_c = 6'(rand_bits(6));
        a_addr = ADDR_W'(slot_a) << 6;
        b_addr = ADDR_W'(slot_b) << 6;
        c_addr = ADDR_W'(slot_c) << 6;

        // signed 8-bit elements, A column-major and B row-major
        for (int i = 0; i < TILE_N; i++) begin
            for (int k = 0; k < TILE_N; k++) begin
                e = 8'(rand_bits(8));
                a_m[i][k] = {{24{e[7]}}, e};
                mem_model.mem[a_addr / 4 + k * TILE_N + i] = a_m[i][k];
                e = 8'(rand_bits(8));
                b_m[k][i] = {{24{e[7]}}, e};
                mem_model.mem[b_addr / 4 + k * TILE_N + i] = b_m[k][i];
            end
        end
        // stale pattern in C so an unwritten word shows up
        for (int w = 0; w < TILE_N * TILE_N; w++)
            mem_model.mem[c_addr / 4 + w] = (c_addr + 4 * w) ^ 32'h5a5a_5a5a;
        mem_model.clear_log();
        interleave = ilv;

        reg_read(REG_STATUS, rd);
        check_word("status before start", 32'(job != 0), rd);
        reg_write(REG_A_ADDR, a_addr);
        reg_write(REG_B_ADDR, b_addr);
        reg_write(REG_C_ADDR, c_addr);
        reg_read(REG_A_ADDR, rd);
        check_word("reg A address", a_addr, rd);
        reg_read(REG_B_ADDR, rd);
        check_word("reg B address", b_addr, rd);
        reg_read(REG_C_ADDR, rd);
        check_word("reg C address", c_addr, rd);

        reg_write(REG_CTRL, 32'h1);
        // start pulse is high now, flag clears on the next edge
        @(posedge clk);
        #1;
        check_state("done_o after start", 1'b0, done);
        while (!done) begin
            @(posedge clk);
            #1;
        end

        reg_read(REG_STATUS, rd);
        check_word("status after job", 32'h1, rd);
        check_addr("araddr of A", a_addr, mem_model.ar_seen[0]);
        check_addr("araddr of B", b_addr, mem_model.ar_seen[1]);
        check_addr("awaddr", c_addr, mem_model.aw_seen);
        check_word("W beat count", 32'd16, mem_model.w_beats);
        // reference product, 32-bit wraparound
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                c_exp = '0;
                for (int k = 0; k < TILE_N; k++)
                    c_exp = c_exp + a_m[i][k] * b_m[k][j];
                check_word($sformatf("C[%0d][%0d]", i, j), c_exp,
                           mem_model.mem[c_addr / 4 + i * TILE_N + j]);
            end
        end
    endtask

    initial begin
        #(NUM_JOBS * JOB_CYCLES * CLK_PERIOD);
        abort_run("timeout: the jobs did not finish within the expected time");
    end

    initial begin
        logic [DATA_W-1:0] rd;
        rst_n      = 1'b0;
        reg_we     = 1'b0;
        reg_addr   = REG_STATUS;
        reg_wdata  = '0;
        stall_ar   = 1'b0;
        stall_r    = 1'b0;
        stall_aw   = 1'b0;
        stall_w    = 1'b0;
        stall_b    = 1'b0;
        interleave = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle after reset: flag clear, addresses zero, no bus requests
        check_state("done_o after reset", 1'b0, done);
        for (int r = 0; r < 5; r++) begin
            reg_read(reg_addr_e'(r), rd);
            check_word($sformatf("register %0d after reset", r), '0, rd);
        end
        repeat (8) begin
            check_state("arvalid_o before start", 1'b0, arvalid);
            check_state("awvalid_o before start", 1'b0, awvalid);
            check_state("wvalid_o before start", 1'b0, wvalid);
            check_state("rready_o before start", 1'b0, rready);
            check_state("bready_o before start", 1'b0, bready);
            @(posedge clk);
            #1;
        end

        // job 0 keeps A before B, job 1 alternates read IDs, the rest pick at random
        run_job(0, 1'b0);
        run_job(1, 1'b1);
        for (int j = 2; j < NUM_JOBS; j++)
            run_job(j, rand_bits(1) != 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sim/tb_axi_mem.sv
/*
 * AXI slave memory for the accelerator testbench: word-addressed storage,
 * per-cycle stall inputs, optional A/B interleaving of read beats and a log
 * of bus addresses and protocol violations that the testbench checks
 */
`timescale 1ns/1ps

module tb_axi_mem import axi_pkg::*; #(
    parameter int WORDS = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    // per-cycle stall requests from the testbench
    input  logic              stall_ar_i,
    input  logic              stall_r_i,
    input  logic              stall_aw_i,
    input  logic              stall_w_i,
    input  logic              stall_b_i,
    input  logic              interleave_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    input  logic [ADDR_W-1:0] araddr_i,
    input  axi_id_e           arid_i,
    output logic              rvalid_o,
    input  logic              rready_i,
    output logic [DATA_W-1:0] rdata_o,
    output axi_id_e           rid_o,
    output logic              rlast_o,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [ADDR_W-1:0] awaddr_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic              wlast_i,
    output logic              bvalid_o,
    input  logic              bready_i,
    output axi_resp_e         bresp_o
);

    logic [DATA_W-1:0] mem [WORDS];
    // bus log of the current job
    logic [ADDR_W-1:0] ar_seen [2];
    logic [ADDR_W-1:0] aw_seen;
    logic [31:0]       w_beats;
    string             proto_msg = "";

    // one read burst per ID
    logic [1:0]        r_act;
    int unsigned       r_base [2];
    int unsigned       r_cnt [2];
    axi_id_e           last_id;
    int unsigned       w_base;
    int unsigned       w_cnt;
    logic              aw_open;
    logic              b_pend;
    // next values, driven 1 ns after the rising edge
    logic              rvalid_n;
    logic              rlast_n;
    logic [DATA_W-1:0] rdata_n;
    axi_id_e           rid_n;
    logic              bvalid_n;
    // payload seen while valid waited on ready
    logic              ar_wait;
    logic              aw_wait;
    logic              w_wait;
    logic [ADDR_W-1:0] ar_addr_p;
    axi_id_e           ar_id_p;
    logic [ADDR_W-1:0] aw_addr_p;
    logic [DATA_W-1:0] w_data_p;
    logic              w_last_p;

    assign arready_o = !stall_ar_i;
    assign awready_o = !stall_aw_i;
    assign wready_o  = !stall_w_i;
    assign bresp_o   = RESP_OKAY;

    task automatic clear_log();
        ar_seen[0] = '1;
        ar_seen[1] = '1;
        aw_seen    = '1;
        w_beats    = '0;
    endtask

    // keep only the first violation
    task automatic note_violation(input string msg);
        if (proto_msg == "")
            proto_msg = msg;
    endtask

    initial begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        rid_o    = ID_A;
        rlast_o  = 1'b0;
        bvalid_o = 1'b0;
        rvalid_n = 1'b0;
        rdata_n  = '0;
        rid_n    = ID_A;
        rlast_n  = 1'b0;
        bvalid_n = 1'b0;
    end

    // mid-cycle sampling, everything is settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            r_act    = '0;
            last_id  = ID_B;
            aw_open  = 1'b0;
            b_pend   = 1'b0;
            rvalid_n = 1'b0;
            bvalid_n = 1'b0;
            ar_wait  = 1'b0;
            aw_wait  = 1'b0;
            w_wait   = 1'b0;
        end else begin
            if (ar_wait && (!arvalid_i || araddr_i !== ar_addr_p || arid_i !== ar_id_p))
                note_violation("AR request dropped or changed before arready");
            if (arvalid_i && arready_o) begin
                r_act[arid_i]   = 1'b1;
                r_base[arid_i]  = (araddr_i >> 2) % WORDS;
                r_cnt[arid_i]   = 0;
                ar_seen[arid_i] = araddr_i;
            end
            ar_wait   = arvalid_i && !arready_o;
            ar_addr_p = araddr_i;
            ar_id_p   = arid_i;

            if (aw_wait && (!awvalid_i || awaddr_i !== aw_addr_p))
                note_violation("AW request dropped or changed before awready");
            if (awvalid_i && awready_o) begin
                aw_seen = awaddr_i;
                w_base  = (awaddr_i >> 2) % WORDS;
                w_cnt   = 0;
                aw_open = 1'b1;
            end
            aw_wait   = awvalid_i && !awready_o;
            aw_addr_p = awaddr_i;

            if (w_wait && (!wvalid_i || wdata_i !== w_data_p || wlast_i !== w_last_p))
                note_violation("W beat dropped or changed before wready");
            if (wvalid_i && wready_o) begin
                if (!aw_open || w_cnt >= 16) begin
                    note_violation("W beat arrived outside an open 16-beat write burst");
                end else begin
                    if (wlast_i !== (w_cnt == 15))
                        note_violation("wlast does not mark exactly the 16th W beat");
                    mem[(w_base + w_cnt) % WORDS] = wdata_i;
                    w_cnt++;
                    w_beats++;
                    if (wlast_i) begin
                        aw_open = 1'b0;
                        b_pend  = 1'b1;
                    end
                end
            end
            w_wait   = wvalid_i && !wready_o;
            w_data_p = wdata_i;
            w_last_p = wlast_i;

            // retire the accepted read beat
            if (rvalid_o && rready_i) begin
                r_cnt[rid_o]++;
                if (r_cnt[rid_o] == 16)
                    r_act[rid_o] = 1'b0;
                last_id = rid_o;
            end
            // a waiting beat is held as it is
            if (!(rvalid_o && !rready_i)) begin
                rvalid_n = 1'b0;
                if (!stall_r_i && r_act != 2'b00) begin
                    if (interleave_i && r_act[!last_id])
                        rid_n = axi_id_e'(!last_id);
                    else if (r_act[ID_A])
                        rid_n = ID_A;
                    else
                        rid_n = ID_B;
                    rvalid_n = 1'b1;
                    rdata_n  = mem[(r_base[rid_n] + r_cnt[rid_n]) % WORDS];
                    rlast_n  = (r_cnt[rid_n] == 15);
                end
            end

            if (bvalid_o && bready_i)
                b_pend = 1'b0;
            if (!(bvalid_o && !bready_i))
                bvalid_n = b_pend && !stall_b_i;
        end
    end

    always @(posedge clk) begin
        #1;
        rvalid_o = rvalid_n;
        rdata_o  = rdata_n;
        rid_o    = rid_n;
        rlast_o  = rlast_n;
        bvalid_o = bvalid_n;
    end

endmodule

// File: verilog/mm_accel_top.sv
/*
 * matrix-multiply tile top: register block, DMA engine, two operand buffers
 * and the multiply engine; AXI master and register port as plain ports
 */
`timescale 1ns/1ps

module mm_accel_top import mm_pkg::*, axi_pkg::*; #(
    parameter int BUF_AW = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              reg_we_i,
    input  reg_addr_e         reg_addr_i,
    input  logic [DATA_W-1:0] reg_wdata_i,
    output logic [DATA_W-1:0] reg_rdata_o,
    output logic              done_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    output logic [ADDR_W-1:0] araddr_o,
    output axi_id_e           arid_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  logic [DATA_W-1:0] rdata_i,
    input  axi_id_e           rid_i,
    input  logic              rlast_i,
    output logic              awvalid_o,
    input  logic              awready_i,
    output logic [ADDR_W-1:0] awaddr_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output logic [DATA_W-1:0] wdata_o,
    output logic              wlast_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    input  axi_resp_e         bresp_i
);

    // buffer write side from the DMA engine
    logic              a_wr_en, b_wr_en;
    logic [BUF_AW-1:0] a_wr_addr, b_wr_addr;
    logic [LINE_W-1:0] a_wr_data, b_wr_data;
    // buffer read side to the multiply engine
    logic [BUF_AW-1:0] a_rd_addr, b_rd_addr;
    logic [LINE_W-1:0] a_line, b_line;
    logic              mm_start, mm_done;
    accum_t            accum [TILE_N][TILE_N];

    dma_cfg_if cfg_if ();

    dma_cfg_regs u_regs (
        .clk, .rst_n, .reg_we_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o, .done_o,
        .cfg (cfg_if.regs)
    );

    dma_engine #(.BUF_AW(BUF_AW)) u_dma (
        .clk, .rst_n, .cfg (cfg_if.engine),
        .arvalid_o, .arready_i, .araddr_o, .arid_o,
        .rvalid_i, .rready_o, .rdata_i, .rid_i, .rlast_i,
        .awvalid_o, .awready_i, .awaddr_o,
        .wvalid_o, .wready_i, .wdata_o, .wlast_o,
        .bvalid_i, .bready_o, .bresp_i,
        .buf_a_wr_en_o (a_wr_en), .buf_a_wr_addr_o (a_wr_addr), .buf_a_wr_data_o (a_wr_data),
        .buf_b_wr_en_o (b_wr_en), .buf_b_wr_addr_o (b_wr_addr), .buf_b_wr_data_o (b_wr_data),
        .mm_start_o (mm_start), .mm_done_i (mm_done), .accum_i (accum)
    );

    // A lines are columns, B lines are rows
    tile_buffer #(.BUF_AW(BUF_AW)) buf_a (
        .clk, .wr_en_i (a_wr_en), .wr_addr_i (a_wr_addr), .wr_data_i (a_wr_data),
        .rd_addr_i (a_rd_addr), .rd_data_o (a_line)
    );

    tile_buffer #(.BUF_AW(BUF_AW)) buf_b (
        .clk, .wr_en_i (b_wr_en), .wr_addr_i (b_wr_addr), .wr_data_i (b_wr_data),
        .rd_addr_i (b_rd_addr), .rd_data_o (b_line)
    );

    mm_engine #(.BUF_AW(BUF_AW)) u_mm (
        .clk, .rst_n, .start_i (mm_start),
        .a_rd_addr_o (a_rd_addr), .b_rd_addr_o (b_rd_addr),
        .a_line_i (a_line), .b_line_i (b_line),
        .done_o (mm_done), .accum_o (accum)
    );

endmodule

// File: verilog/mm_engine.sv
/*
 * 4x4 multiply engine: streams line k of A (column) and B (row) and adds
 * their outer product into sixteen accumulators, done six cycles after start
 */
`timescale 1ns/1ps

module mm_engine import mm_pkg::*; #(
    parameter int BUF_AW = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    output logic [BUF_AW-1:0] a_rd_addr_o,
    output logic [BUF_AW-1:0] b_rd_addr_o,
    input  logic [LINE_W-1:0] a_line_i,
    input  logic [LINE_W-1:0] b_line_i,
    output logic              done_o,
    output accum_t            accum_o [TILE_N][TILE_N]
);

    localparam int LANE_W = $clog2(TILE_N);

    logic [LANE_W-1:0]        rd_cnt;
    logic                     rd_busy;
    // buffer data valid this cycle
    logic                     line_vld;
    logic [LANE_W-1:0]        acc_cnt;
    logic signed [ELEM_W-1:0] a_elem [TILE_N];
    logic signed [ELEM_W-1:0] b_elem [TILE_N];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt   <= '0;
            rd_busy  <= 1'b0;
            line_vld <= 1'b0;
            acc_cnt  <= '0;
            done_o   <= 1'b0;
        end else begin
            line_vld <= rd_busy;
            done_o   <= line_vld && acc_cnt == LANE_W'(TILE_N - 1);
            if (line_vld)
                acc_cnt <= acc_cnt + 1'b1;
            if (start_i) begin
                rd_cnt  <= '0;
                rd_busy <= 1'b1;
                acc_cnt <= '0;
            end else if (rd_busy) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == LANE_W'(TILE_N - 1))
                    rd_busy <= 1'b0;
            end
        end
    end

    // same line index for both operands
    assign a_rd_addr_o = BUF_AW'(rd_cnt);
    assign b_rd_addr_o = BUF_AW'(rd_cnt);

    always_comb begin
        for (int i = 0; i < TILE_N; i++) begin
            a_elem[i] = a_line_i[i*ELEM_W +: ELEM_W];
            b_elem[i] = b_line_i[i*ELEM_W +: ELEM_W];
        end
    end

    // broadcast outer product, all sixteen cells in one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                if (start_i)
                    accum_o[i][j] <= '0;
                else if (line_vld)
                    accum_o[i][j] <= accum_o[i][j] + a_elem[i] * b_elem[j];
            end
        end
    end

endmodule

// File: verilog/tile_buffer.sv
/*
 * operand line memory, one write port and one registered read port
 * holds one 128-bit row or column per line
 */
`timescale 1ns/1ps

module tile_buffer import mm_pkg::*; #(
    parameter int BUF_AW = 2
) (
    input  logic              clk,
    input  logic              wr_en_i,
    input  logic [BUF_AW-1:0] wr_addr_i,
    input  logic [LINE_W-1:0] wr_data_i,
    input  logic [BUF_AW-1:0] rd_addr_i,
    output logic [LINE_W-1:0] rd_data_o
);

    logic [LINE_W-1:0] mem [2**BUF_AW];

    // read data appears one cycle after the address
    always_ff @(posedge clk) begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// File: verilog/dma_engine.sv
/*
 * job sequencer: reads A and B over AXI, packs beats into buffer lines,
 * launches the multiply engine and writes C back in one burst
 */
`timescale 1ns/1ps

module dma_engine import mm_pkg::*, axi_pkg::*; #(
    parameter int BUF_AW = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    dma_cfg_if.engine         cfg,
    output logic              arvalid_o,
    input  logic              arready_i,
    output logic [ADDR_W-1:0] araddr_o,
    output axi_id_e           arid_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  logic [DATA_W-1:0] rdata_i,
    input  axi_id_e           rid_i,
    input  logic              rlast_i,
    output logic              awvalid_o,
    input  logic              awready_i,
    output logic [ADDR_W-1:0] awaddr_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output logic [DATA_W-1:0] wdata_o,
    output logic              wlast_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    input  axi_resp_e         bresp_i,
    output logic              buf_a_wr_en_o,
    output logic [BUF_AW-1:0] buf_a_wr_addr_o,
    output logic [LINE_W-1:0] buf_a_wr_data_o,
    output logic              buf_b_wr_en_o,
    output logic [BUF_AW-1:0] buf_b_wr_addr_o,
    output logic [LINE_W-1:0] buf_b_wr_data_o,
    output logic              mm_start_o,
    input  logic              mm_done_i,
    input  accum_t            accum_i [TILE_N][TILE_N]
);

    localparam int LANE_W = $clog2(TILE_N);
    localparam int BEAT_W = $clog2(TILE_N * TILE_N);

    dma_state_e state_q, state_d;

    // per-ID packing state, index 0 is A and 1 is B
    logic [1:0]              r_hs;
    logic [BEAT_W-1:0]       beat_cnt [2];
    logic [1:0]              last_seen;
    logic [1:0]              wr_en_q;
    logic [BUF_AW-1:0]       wr_addr_q [2];
    logic [LINE_W-1:0]       pack_q [2];
    logic [BEAT_W-1:0]       w_cnt;
    logic                    w_hs;
    logic                    load_done;

    // rready stays high for the whole load phase
    assign rready_o  = (state_q == ST_LOAD);
    assign w_hs      = wvalid_o && wready_i;
    assign load_done = (&last_seen) && !(|wr_en_q);

    for (genvar g = 0; g < 2; g++) begin : g_pack
        assign r_hs[g] = rvalid_i && rready_o && rid_i == axi_id_e'(g);

        // shift right so the first beat of four ends up in lane 0
        always_ff @(posedge clk) begin
            if (r_hs[g]) begin
                pack_q[g]    <= {rdata_i, pack_q[g][LINE_W-1:ELEM_W]};
                wr_addr_q[g] <= BUF_AW'(beat_cnt[g][BEAT_W-1:LANE_W]);
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                beat_cnt[g]  <= '0;
                last_seen[g] <= 1'b0;
                wr_en_q[g]   <= 1'b0;
            end else begin
                // line write follows its fourth beat by one cycle
                wr_en_q[g] <= r_hs[g] && beat_cnt[g][LANE_W-1:0] == LANE_W'(TILE_N - 1);
                if (cfg.start && state_q == ST_IDLE) begin
                    beat_cnt[g]  <= '0;
                    last_seen[g] <= 1'b0;
                end else if (r_hs[g]) begin
                    beat_cnt[g]  <= beat_cnt[g] + 1'b1;
                    last_seen[g] <= last_seen[g] | rlast_i;
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (cfg.start) state_d = ST_AR_A;
            ST_AR_A:    if (arready_i) state_d = ST_AR_B;
            ST_AR_B:    if (arready_i) state_d = ST_LOAD;
            ST_LOAD:    if (load_done) state_d = ST_WAIT_MM;
            ST_WAIT_MM: if (mm_done_i) state_d = ST_AW;
            ST_AW:      if (awready_i) state_d = ST_W;
            ST_W:       if (w_hs && wlast_o) state_d = ST_B;
            ST_B:       if (bvalid_i) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            mm_start_o <= 1'b0;
            w_cnt      <= '0;
        end else begin
            state_q    <= state_d;
            // launch multiply on the first wait cycle
            mm_start_o <= (state_q == ST_LOAD) && load_done;
            if (state_q == ST_AW)
                w_cnt <= '0;
            else if (w_hs)
                w_cnt <= w_cnt + 1'b1;
        end
    end

    // read address, payload held steady while valid waits
    assign arvalid_o = (state_q == ST_AR_A) || (state_q == ST_AR_B);
    assign araddr_o  = (state_q == ST_AR_B) ? cfg.b_addr : cfg.a_addr;
    assign arid_o    = (state_q == ST_AR_B) ? ID_B : ID_A;

    assign awvalid_o = (state_q == ST_AW);
    assign awaddr_o  = cfg.c_addr;

    // row-major C, low word of each sum
    assign wvalid_o = (state_q == ST_W);
    assign wdata_o  = accum_i[w_cnt[BEAT_W-1:LANE_W]][w_cnt[LANE_W-1:0]][DATA_W-1:0];
    assign wlast_o  = (w_cnt == BEAT_W'(TILE_N * TILE_N - 1));

    assign bready_o = (state_q == ST_B);
    assign cfg.done = bready_o && bvalid_i;

    assign buf_a_wr_en_o   = wr_en_q[ID_A];
    assign buf_a_wr_addr_o = wr_addr_q[ID_A];
    assign buf_a_wr_data_o = pack_q[ID_A];
    assign buf_b_wr_en_o   = wr_en_q[ID_B];
    assign buf_b_wr_addr_o = wr_addr_q[ID_B];
    assign buf_b_wr_data_o = pack_q[ID_B];

endmodule

// File: verilog/dma_cfg_regs.sv
/*
 * software register block: three job addresses, control and sticky status
 * writes take effect on reg_we_i, reads are combinational
 */
`timescale 1ns/1ps

module dma_cfg_regs import mm_pkg::*, axi_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              reg_we_i,
    input  reg_addr_e         reg_addr_i,
    input  logic [DATA_W-1:0] reg_wdata_i,
    output logic [DATA_W-1:0] reg_rdata_o,
    output logic              done_o,
    dma_cfg_if.regs           cfg
);

    logic [ADDR_W-1:0] a_addr_q, b_addr_q, c_addr_q;
    logic              start_q;
    logic              done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_addr_q <= '0;
            b_addr_q <= '0;
            c_addr_q <= '0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            if (reg_we_i && reg_addr_i == REG_A_ADDR) a_addr_q <= reg_wdata_i;
            if (reg_we_i && reg_addr_i == REG_B_ADDR) b_addr_q <= reg_wdata_i;
            if (reg_we_i && reg_addr_i == REG_C_ADDR) c_addr_q <= reg_wdata_i;
            // control bit 0 becomes a start pulse one cycle later
            start_q <= reg_we_i && reg_addr_i == REG_CTRL && reg_wdata_i[0];
            // sticky done, a new job clears it
            if (start_q)
                done_q <= 1'b0;
            else if (cfg.done)
                done_q <= 1'b1;
        end
    end

    always_comb begin
        case (reg_addr_i)
            REG_A_ADDR: reg_rdata_o = a_addr_q;
            REG_B_ADDR: reg_rdata_o = b_addr_q;
            REG_C_ADDR: reg_rdata_o = c_addr_q;
            REG_STATUS: reg_rdata_o = {{(DATA_W-1){1'b0}}, done_q};
            default:    reg_rdata_o = '0;
        endcase
    end

    assign cfg.a_addr = a_addr_q;
    assign cfg.b_addr = b_addr_q;
    assign cfg.c_addr = c_addr_q;
    assign cfg.start  = start_q;
    assign done_o     = done_q;

endmodule

// File: verilog/dma_cfg_if.sv
/*
 * job description from the register block to the DMA engine
 * start and done are single-cycle pulses
 */
`timescale 1ns/1ps

interface dma_cfg_if import axi_pkg::*; ();

    // byte addresses of A, B and C
    logic [ADDR_W-1:0] a_addr;
    logic [ADDR_W-1:0] b_addr;
    logic [ADDR_W-1:0] c_addr;
    logic              start;
    logic              done;

    modport regs (
        output a_addr, b_addr, c_addr, start,
        input  done
    );

    modport engine (
        input  a_addr, b_addr, c_addr, start,
        output done
    );

endinterface

// File: verilog/axi_pkg.sv
/*
 * field widths and encodings of the simplified AXI bus used by the DMA engine
 */
package axi_pkg;

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;

    // one read ID per operand burst
    typedef enum logic [0:0] {
        ID_A = 1'b0,
        ID_B = 1'b1
    } axi_id_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

// File: verilog/mm_pkg.sv
/*
 * tile geometry, element and accumulator types for the matrix-multiply tile
 * plus the register map and DMA sequencing states; imported by the RTL
 */
package mm_pkg;

    // tile edge in elements
    parameter int TILE_N = 4;
    // one matrix element
    parameter int ELEM_W = 32;
    // one buffer line holds a full row or column
    parameter int LINE_W = TILE_N * ELEM_W;

    // product of two elements plus one guard bit
    typedef logic signed [2*ELEM_W:0] accum_t;

    // software register map, word index
    typedef enum logic [2:0] {
        REG_A_ADDR = 3'd0,
        REG_B_ADDR = 3'd1,
        REG_C_ADDR = 3'd2,
        REG_CTRL   = 3'd3,
        REG_STATUS = 3'd4
    } reg_addr_e;

    // job sequencing in the DMA engine
    typedef enum logic [2:0] {
        ST_IDLE, ST_AR_A, ST_AR_B, ST_LOAD,
        ST_WAIT_MM, ST_AW, ST_W, ST_B
    } dma_state_e;

endpackage
